// File: rtl/stDataPkg.sv
// shared widths and codes of the SD-card and ROM data path, RAM_ADDR_BITS is set per instance
package stDataPkg;

	// plain vectors with a meaning of their own
	typedef logic [15:0] wordT;    // ram data word and control register value
	typedef logic [7:0]  byteT;    // spi command byte or dma status byte
	typedef logic [22:0] ramAddrT; // word address as the ram host sees it
	typedef logic [1:0]  busCycleT; // bus slot phase, 3 is the last video phase
	typedef logic [4:0]  dmaIdxT;  // payload byte index into the dma status window

	// command byte sent first in every spi transfer
	typedef enum byteT {
		cmdSetAddr   = 8'd1, // 31 bit word address follows
		cmdWrite     = 8'd2, // words to store, address auto increments
		cmdRead      = 8'd3, // words to fetch, first one pre-issued
		cmdSetCtrl   = 8'd4, // one control word
		cmdDmaStatus = 8'd5, // status bytes shifted out
		cmdDmaAck    = 8'd6  // acknowledge of a dma request
	} spiCmdT;

	// state code handed to the ram host each clk_8 cycle
	typedef enum logic [2:0] {
		hostDecode = 3'b001, // idle
		hostRead   = 3'b010, // fetch word at addr
		hostWrite  = 3'b011, // store dataOut at addr
		hostReset  = 3'b101  // held while the core is in reset
	} hostStateT;

	// control register bit whose rising edge raises a dma request
	localparam int DMA_REQ_BIT = 0;

endpackage

// File: rtl/spiDataClient.sv
// no back-pressure, sck must be 16 or more clk_8 periods and spiSel low half a bit past the end
`timescale 1ns/1ps

module spiDataClient (
	input  logic                clk_8,
	input  logic                ss,
	input  stDataPkg::busCycleT busCycle,
	output stDataPkg::wordT     ctrlOut,

	input  logic                sdi,
	input  logic                sck,
	input  logic                spiSel,  // spi chip select, high between transfers
	output logic                sdo,

	output stDataPkg::dmaIdxT   dmaIdx,
	input  stDataPkg::byteT     dmaData,
	output logic                dmaAck,

	output stDataPkg::hostStateT state,  // state code driving the ram host
	output stDataPkg::ramAddrT  addr,
	output stDataPkg::wordT     dataOut, // write data
	input  stDataPkg::wordT     dataIn
);
	import stDataPkg::*;

	logic [4:0]  cnt;     // bit counter, command on 0..7 then rolling 8..23
	dmaIdxT      bcnt;    // payload byte counter
	logic [14:0] sbuf;    // receive shift register
	byteT        cmd;     // command of the current transfer
	byteT        cmdByte; // command byte as it completes on bit 7
	logic [30:0] addrR;   // word address register
	logic        write;   // write request, sck domain
	logic        writeD;  // write taken into clk_8 at the io slot
	logic        writeD2; // one clk_8 later, for the edge
	logic        read;    // read request, sck domain
	logic        readD;
	logic        readD2;
	wordT        txData;  // transmit shift register

	assign cmdByte = {sbuf[6:0], sdi};
	assign dmaIdx  = bcnt;
	assign sdo     = txData[15]; // msb first

	// address is bumped at the end of each written word, so writes land one below
	assign addr = addrR[22:0] - ((cmd == cmdWrite) ? 23'd1 : 23'd0);

	// requests enter clk_8 only after bus cycle 3 and stay up as long as the request
	always_ff @(posedge clk_8, posedge ss) begin
		if (ss) begin
			writeD  <= 1'b0;
			writeD2 <= 1'b0;
			readD   <= 1'b0;
			readD2  <= 1'b0;
			state   <= hostReset;
		end else begin
			writeD  <= write && ((busCycle == 2'd3) || writeD);
			writeD2 <= writeD;
			readD   <= read && ((busCycle == 2'd3) || readD);
			readD2  <= readD;

			if (writeD && !writeD2)
				state <= hostWrite;  // one cycle per request
			else if (readD && !readD2)
				state <= hostRead;
			else
				state <= hostDecode;
		end
	end

	// bit and byte counting, request flags
	always_ff @(posedge sck, posedge spiSel) begin
		if (spiSel) begin
			cnt    <= 5'd0;
			bcnt   <= '0;
			write  <= 1'b0;
			read   <= 1'b0;
			dmaAck <= 1'b0;
		end else begin
			dmaAck <= 1'b0; // single sck pulse

			if (cnt < 5'd23)
				cnt <= cnt + 5'd1;
			else
				cnt <= 5'd8; // next payload word

			if ((cnt == 5'd15) || (cnt == 5'd23))
				bcnt <= bcnt + 5'd1; // one per payload byte

			if (cnt == 5'd7) begin
				if (cmdByte == cmdDmaAck)
					dmaAck <= 1'b1;
				if (cmdByte == cmdRead)
					read <= 1'b1; // fetch first word before it is shifted out
			end

			if (cnt >= 5'd8) begin
				if (cmd == cmdWrite) begin
					if (cnt == 5'd16)
						write <= 1'b0; // drop midway so the next word makes an edge
					if (cnt == 5'd23)
						write <= 1'b1;
				end
				if (cmd == cmdRead) begin
					if (cnt == 5'd16)
						read <= 1'b0;
					if (cnt == 5'd23)
						read <= 1'b1; // prefetch the following word
				end
			end
		end
	end

	// command and control register survive between transfers
	always_ff @(posedge sck, posedge ss) begin
		if (ss) begin
			cmd     <= '0;
			ctrlOut <= '0;
		end else if (!spiSel) begin
			if (cnt == 5'd7)
				cmd <= cmdByte;
			if ((cmd == cmdSetCtrl) && (cnt == 5'd23))
				ctrlOut <= {sbuf, sdi};
		end
	end

	// payload shifting, address and write data
	always_ff @(posedge sck) begin
		sbuf <= {sbuf[13:0], sdi};
		if (cnt >= 5'd8) begin
			if (cmd == cmdSetAddr)
				addrR <= {addrR[29:0], sdi}; // keeps the last 31 bits
			if ((cmd == cmdWrite) && (cnt == 5'd23)) begin
				dataOut <= {sbuf, sdi};
				addrR   <= addrR + 31'd1;
			end
			if ((cmd == cmdRead) && (cnt == 5'd23))
				addrR <= addrR + 31'd1;
		end
	end

	// transmit side shifts on falling sck so the master samples on rising
	always_ff @(negedge sck, posedge spiSel) begin
		if (spiSel)
			txData <= '0;
		else if ((cmd == cmdRead) && (cnt == 5'd8))
			txData <= dataIn;            // word fetched during the last half word
		else if ((cmd == cmdDmaStatus) && ((cnt == 5'd8) || (cnt == 5'd16)))
			txData[15:8] <= dmaData;     // status byte selected by bcnt
		else
			txData <= {txData[14:0], 1'b0};
	end

endmodule

// File: rtl/ramHost.sv
// stand-in for the sdram host, only the low RAM_ADDR_BITS of addr decode so higher bits alias
`timescale 1ns/1ps

module ramHost #(
	parameter int RAM_ADDR_BITS = 10 // word address bits decoded, up to 23
) (
	input  logic                 clk_8,
	input  logic                 ss,
	input  stDataPkg::hostStateT state,   // state code from the spi client
	input  stDataPkg::ramAddrT   addr,
	input  stDataPkg::wordT      dataOut, // write data from the client
	output stDataPkg::wordT      dataIn,  // read data, held until the next read
	output stDataPkg::busCycleT  busCycle
);
	import stDataPkg::*;

	localparam int MEM_WORDS = 1 << RAM_ADDR_BITS;

	wordT mem [0:MEM_WORDS-1]; // word memory

	logic [RAM_ADDR_BITS-1:0] memIdx;  // decoded word index
	logic                     wrStb;   // store this cycle
	logic                     rdStb;   // fetch this cycle

	assign memIdx = addr[RAM_ADDR_BITS-1:0];
	assign wrStb  = (state == hostWrite);
	assign rdStb  = (state == hostRead);

	// slot schedule, 0..3 with the io slot right after phase 3
	always_ff @(posedge clk_8, posedge ss) begin
		if (ss)
			busCycle <= '0;
		else
			busCycle <= busCycle + 2'd1; // free running
	end

	// write port
	always_ff @(posedge clk_8) begin
		if (wrStb)
			mem[memIdx] <= dataOut; // stored at the end of the write cycle
	end

	// read port, result one cycle after the read code
	always_ff @(posedge clk_8, posedge ss) begin
		if (ss)
			dataIn <= '0;
		else if (rdStb)
			dataIn <= mem[memIdx];
	end

endmodule

// File: rtl/dmaStatus.sv
// counters move two to three clk_8 cycles after a request edge or ack, pending saturates at zero
`timescale 1ns/1ps

module dmaStatus (
	input  logic              clk_8,
	input  logic              ss,
	input  stDataPkg::wordT   ctrlOut, // control register, sck domain
	input  logic              dmaAck,  // one sck wide pulse
	input  stDataPkg::dmaIdxT dmaIdx,  // status byte index
	output stDataPkg::byteT   dmaData
);
	import stDataPkg::*;

	logic [2:0] reqSync;  // two sync flops and the previous value
	logic [2:0] ackSync;
	logic       reqEdge;  // request bit rose
	logic       ackEdge;  // ack pulse arrived
	byteT       pending;  // requests not yet acknowledged
	byteT       ackTotal; // acknowledges seen since reset
	wordT       snapshot; // control value at the last request

	assign reqEdge = reqSync[1] && !reqSync[2];
	assign ackEdge = ackSync[1] && !ackSync[2];

	always_ff @(posedge clk_8, posedge ss) begin
		if (ss) begin
			reqSync  <= '0;
			ackSync  <= '0;
			pending  <= '0;
			ackTotal <= '0;
			snapshot <= '0;
		end else begin
			reqSync <= {reqSync[1:0], ctrlOut[DMA_REQ_BIT]};
			ackSync <= {ackSync[1:0], dmaAck};

			if (reqEdge)
				snapshot <= ctrlOut; // settled long before the synced edge
			if (ackEdge)
				ackTotal <= ackTotal + 8'd1;

			// request and ack together leave pending as it is
			if (reqEdge && !ackEdge)
				pending <= pending + 8'd1;
			else if (ackEdge && !reqEdge && (pending != 8'd0))
				pending <= pending - 8'd1;
		end
	end

	// status window read by byte index
	always_comb begin
		case (dmaIdx)
			5'd0:    dmaData = pending;
			5'd1:    dmaData = ackTotal;
			5'd2:    dmaData = snapshot[15:8];
			5'd3:    dmaData = snapshot[7:0];
			default: dmaData = '0; // rest of the 32 byte window reads 0
		endcase
	end

endmodule

// File: rtl/stDataTop.sv
// sck period must be 16 or more clk_8 periods, spiSel low half a bit after the last, no back-pressure
`timescale 1ns/1ps

module stDataTop #(
	parameter int RAM_ADDR_BITS = 10 // ram words decoded by the host
) (
	input  logic            clk_8,
	input  logic            ss,
	input  logic            sck,
	input  logic            sdi,
	input  logic            spiSel,
	output logic            sdo,
	output stDataPkg::wordT ctrlOut
);
	import stDataPkg::*;

	hostStateT state;    // client to host state code
	ramAddrT   addr;
	wordT      dataOut;
	wordT      dataIn;
	busCycleT  busCycle;
	dmaIdxT    dmaIdx;
	logic      dmaAck;
	byteT      dmaData;

	spiDataClient client (
		.clk_8    (clk_8),
		.ss       (ss),
		.busCycle (busCycle),
		.ctrlOut  (ctrlOut),
		.sdi      (sdi),
		.sck      (sck),
		.spiSel   (spiSel),
		.sdo      (sdo),
		.dmaIdx   (dmaIdx),
		.dmaData  (dmaData),
		.dmaAck   (dmaAck),
		.state    (state),
		.addr     (addr),
		.dataOut  (dataOut),
		.dataIn   (dataIn)
	);

	ramHost #(
		.RAM_ADDR_BITS (RAM_ADDR_BITS)
	) host (
		.clk_8    (clk_8),
		.ss       (ss),
		.state    (state),
		.addr     (addr),
		.dataOut  (dataOut),
		.dataIn   (dataIn),
		.busCycle (busCycle)
	);

	dmaStatus dma (
		.clk_8   (clk_8),
		.ss      (ss),
		.ctrlOut (ctrlOut),
		.dmaAck  (dmaAck),
		.dmaIdx  (dmaIdx),
		.dmaData (dmaData)
	);

endmodule

// File: testbench/tbClock.sv
// clock runs from time zero, ss is released one ns after the last reset edge
`timescale 1ns/1ps

module tbClock #(
	parameter int PERIOD_NS    = 100, // clk_8 period
	parameter int RESET_CYCLES = 8    // rising edges with ss held high
) (
	output logic clk_8,
	output logic ss
);

	initial begin
		clk_8 = 1'b0;
		forever #(PERIOD_NS / 2) clk_8 = ~clk_8;
	end

	initial begin
		ss = 1'b1; // asserted from time zero
		repeat (RESET_CYCLES) @(posedge clk_8);
		#1 ss = 1'b0;
	end

endmodule

// File: testbench/stDataTb.sv
// spi master runs 16 clk_8 per bit and ram read-back is predicted by a shadow of the written words
`timescale 1ns/1ps

module stDataTb;
	import stDataPkg::*;

	localparam int CLK_NS      = 100;
	localparam int RAM_BITS    = 10; // decoded word address bits in the ram host
	localparam int MAX_WORDS   = 4;  // payload words per transfer
	localparam int ROWS        = 19;
	localparam int XFER_NS     = (8 + 16 * MAX_WORDS) * 16 * CLK_NS + 40 * CLK_NS;
	localparam int WATCHDOG_NS = 2 * ROWS * XFER_NS + 20 * CLK_NS; // twice the table plus reset

	logic clk_8;
	logic ss;
	logic sck;
	logic sdi;
	logic spiSel;
	logic sdo;
	wordT ctrlOut;

	byteT rowCmd   [ROWS];    // command byte of each transfer
	int   rowWords [ROWS];    // payload word count
	wordT rowData  [ROWS][2]; // address, control or unused payload
	wordT rowExp   [ROWS][2]; // expected status words or control value
	int   rowCount;

	wordT        txWords [MAX_WORDS];
	wordT        rxWords [MAX_WORDS];
	wordT        shadow  [0:(1 << RAM_BITS) - 1]; // predicted ram contents
	logic [30:0] curAddr; // mirror of the client address register
	logic [31:0] lfsr;
	int          errors;
	int          checks;

	tbClock #(
		.PERIOD_NS    (CLK_NS),
		.RESET_CYCLES (8)
	) clkGen (
		.clk_8 (clk_8),
		.ss    (ss)
	);

	stDataTop #(
		.RAM_ADDR_BITS (RAM_BITS)
	) uut (
		.clk_8   (clk_8),
		.ss      (ss),
		.sck     (sck),
		.sdi     (sdi),
		.spiSel  (spiSel),
		.sdo     (sdo),
		.ctrlOut (ctrlOut)
	);

	task automatic clkWait(input int n);
		repeat (n) @(posedge clk_8);
		#1; // inputs move just after the edge
	endtask

	// taps of x^32 + x^22 + x^2 + x + 1 with the new bit entering at the bottom
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		lfsrNext = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic randWord(output wordT w);
		int i;
		w = '0;
		for (i = 0; i < 16; i++) begin
			lfsr = lfsrNext(lfsr); // one step per bit
			w    = {w[14:0], lfsr[0]};
		end
	endtask

	// one sck period with the low half first
	task automatic spiBit(input logic b, output logic r);
		sdi = b;
		clkWait(8);
		r   = sdo; // client changed it on the last falling edge
		sck = 1'b1;
		clkWait(8);
		sck = 1'b0;
	endtask

	task automatic spiTransfer(input byteT cmd, input int nWords);
		logic r;
		int   w;
		int   b;
		spiSel = 1'b0;
		for (b = 7; b >= 0; b--)
			spiBit(cmd[b], r); // msb first
		for (w = 0; w < nWords; w++) begin
			for (b = 15; b >= 0; b--) begin
				spiBit(txWords[w][b], r);
				rxWords[w][b] = r;
			end
		end
		clkWait(8); // a full bit past the last rising sck
		spiSel = 1'b1;
		clkWait(16);
	endtask

	task automatic addRow(input byteT cmd, input int n, input wordT d0, input wordT d1,
		input wordT e0, input wordT e1);
		rowCmd[rowCount]     = cmd;
		rowWords[rowCount]   = n;
		rowData[rowCount][0] = d0;
		rowData[rowCount][1] = d1;
		rowExp[rowCount][0]  = e0;
		rowExp[rowCount][1]  = e1;
		rowCount++;
	endtask

	task automatic buildTable();
		rowCount = 0;
		addRow(cmdDmaStatus, 2, '0, '0, 16'h0000, 16'h0000);      // all zero after reset
		addRow(cmdSetAddr, 2, 16'h0002, 16'h0135, '0, '0);
		addRow(cmdWrite, 4, '0, '0, '0, '0);                        // lfsr words
		addRow(cmdSetAddr, 2, 16'h0002, 16'h0135, '0, '0);
		addRow(cmdRead, 4, '0, '0, '0, '0);                         // same words in order
		addRow(cmdSetAddr, 2, 16'h0000, 16'h02f0, '0, '0);
		addRow(cmdWrite, 1, '0, '0, '0, '0);
		addRow(cmdSetAddr, 2, 16'h0012, 16'h06f0, '0, '0);       // same low 10 bits
		addRow(cmdWrite, 1, '0, '0, '0, '0);
		addRow(cmdSetAddr, 2, 16'h0000, 16'h02f0, '0, '0);
		addRow(cmdRead, 1, '0, '0, '0, '0);                         // later word wins
		addRow(cmdSetCtrl, 1, 16'hc3a4, '0, 16'hc3a4, '0);         // request bit clear
		addRow(cmdDmaStatus, 2, '0, '0, 16'h0000, 16'h0000);
		addRow(cmdSetCtrl, 1, 16'h8e71, '0, 16'h8e71, '0);         // request bit rises
		addRow(cmdDmaStatus, 2, '0, '0, 16'h0100, 16'h8e71);
		addRow(cmdDmaAck, 0, '0, '0, '0, '0);
		addRow(cmdDmaStatus, 2, '0, '0, 16'h0001, 16'h8e71);
		addRow(cmdDmaAck, 0, '0, '0, '0, '0);                      // pending already 0
		addRow(cmdDmaStatus, 2, '0, '0, 16'h0002, 16'h8e71);
	endtask

	task automatic reportMismatch(input string what, input int row, input int idx,
		input wordT got, input wordT exp);
		errors++;
		$display("error at %0d ns: %s in row %0d word %0d, got %h expected %h",
			$time, what, row, idx, got, exp);
	endtask

	initial begin
		int                  r;
		int                  w;
		logic [RAM_BITS-1:0] idx;
		sck     = 1'b0;
		sdi     = 1'b0;
		spiSel  = 1'b1; // spi side held in reset between transfers
		errors  = 0;
		checks  = 0;
		lfsr    = 32'h71b6_b99f;
		curAddr = '0;
		buildTable();
		wait (ss == 1'b0);
		clkWait(4);

		checks++;
		if (ctrlOut !== 16'h0000)
			reportMismatch("ctrlOut after reset", -1, 0, ctrlOut, 16'h0000);

		for (r = 0; r < ROWS; r++) begin
			for (w = 0; w < rowWords[r]; w++) begin
				if (rowCmd[r] == cmdWrite)
					randWord(txWords[w]);
				else if (w < 2)
					txWords[w] = rowData[r][w];
				else
					txWords[w] = '0;
			end
			spiTransfer(rowCmd[r], rowWords[r]);

			case (rowCmd[r])
				cmdSetAddr: curAddr = {rowData[r][0][14:0], rowData[r][1]}; // low 31 bits
				cmdWrite: begin
					for (w = 0; w < rowWords[r]; w++) begin
						shadow[curAddr[RAM_BITS-1:0]] = txWords[w]; // high bits alias
						curAddr = curAddr + 31'd1;
					end
				end
				cmdRead: begin
					for (w = 0; w < rowWords[r]; w++) begin
						idx = curAddr[RAM_BITS-1:0];
						checks++;
						if (rxWords[w] !== shadow[idx])
							reportMismatch("ram read", r, w, rxWords[w], shadow[idx]);
						curAddr = curAddr + 31'd1;
					end
				end
				cmdSetCtrl: begin
					checks++;
					if (ctrlOut !== rowExp[r][0])
						reportMismatch("ctrlOut", r, 0, ctrlOut, rowExp[r][0]);
				end
				cmdDmaStatus: begin
					// {pending, ack total} then the snapshot
					for (w = 0; w < rowWords[r]; w++) begin
						checks++;
						if (rxWords[w] !== rowExp[r][w])
							reportMismatch("dma status", r, w, rxWords[w], rowExp[r][w]);
					end
				end
				default: ;
			endcase
		end

		$display("%0d checks run, %0d errors", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout, the stimulus table did not finish within %0d ns, %0d errors so far",
			WATCHDOG_NS, errors);
		$display("Verification failed");
		$finish;
	end

endmodule

// File: stData.f
rtl/stDataPkg.sv
rtl/spiDataClient.sv
rtl/ramHost.sv
rtl/dmaStatus.sv
rtl/stDataTop.sv
testbench/tbClock.sv
testbench/stDataTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = stDataTb
FILELIST  = stData.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJDIR)
